// File: source/la_pkg.sv
package la_pkg;

    // register bus
    localparam int BUS_WIDTH = 16;

    // address map
    localparam logic [BUS_WIDTH-1:0] TRIG_BASE = 16'd0;
    localparam logic [BUS_WIDTH-1:0] CAP_BASE  = 16'd8;
    localparam logic [BUS_WIDTH-1:0] MEM_BASE  = 16'd16;
    localparam int TRIG_REGS = 8;
    localparam int CAP_REGS  = 3;

    // capture register offsets
    localparam int CAP_CTRL   = 0;
    localparam int CAP_STATUS = 1;
    localparam int CAP_COUNT  = 2;

    // sample buffer geometry
    localparam int SAMPLE_DEPTH       = 16;
    localparam int SAMPLE_WIDTH       = 7;
    localparam int SAMPLE_ADDR_WIDTH  = $clog2(SAMPLE_DEPTH);
    localparam int SAMPLE_COUNT_WIDTH = $clog2(SAMPLE_DEPTH + 1);

    typedef enum logic [3:0] {
        DISABLE  = 4'd0,
        RISING   = 4'd1,
        FALLING  = 4'd2,
        CHANGING = 4'd3,
        GT       = 4'd4,
        LT       = 4'd5,
        GEQ      = 4'd6,
        LEQ      = 4'd7,
        EQ       = 4'd8,
        NEQ      = 4'd9
    } trig_op_e;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        ARMED     = 2'd1,
        CAPTURING = 2'd2,
        DONE      = 2'd3
    } cap_state_e;

endpackage

// File: source/probe_trigger.sv
`timescale 1ns/100ps

module probe_trigger import la_pkg::*; #(
    parameter int INPUT_WIDTH = 1
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [INPUT_WIDTH-1:0] probe_i,
    input  trig_op_e               op_i,
    input  logic [INPUT_WIDTH-1:0] arg_i,
    output logic                   trig_o
);

    logic [INPUT_WIDTH-1:0] probe_prev;

    // last cycle's probe value for edge detection
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            probe_prev <= '0;
        end else begin
            probe_prev <= probe_i;
        end
    end

    always_comb begin
        case (op_i)
            RISING: begin
                trig_o = !probe_prev[0] && probe_i[0];
            end
            FALLING: begin
                trig_o = probe_prev[0] && !probe_i[0];
            end
            CHANGING: begin
                trig_o = (probe_i != probe_prev);
            end
            // unsigned, probe on the left
            GT: begin
                trig_o = (probe_i > arg_i);
            end
            LT: begin
                trig_o = (probe_i < arg_i);
            end
            GEQ: begin
                trig_o = (probe_i >= arg_i);
            end
            LEQ: begin
                trig_o = (probe_i <= arg_i);
            end
            EQ: begin
                trig_o = (probe_i == arg_i);
            end
            NEQ: begin
                trig_o = (probe_i != arg_i);
            end
            // DISABLE and unused codes never fire
            default: begin
                trig_o = 1'b0;
            end
        endcase
    end

endmodule

// File: source/trigger_block.sv
`timescale 1ns/100ps

module trigger_block import la_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n_i,

    input  logic                    probe0_i,
    input  logic                    probe1_i,
    input  logic                    probe2_i,
    input  logic [3:0]              probe3_i,

    input  logic [BUS_WIDTH-1:0]    addr_i,
    input  logic [BUS_WIDTH-1:0]    wdata_i,
    input  logic [BUS_WIDTH-1:0]    rdata_i,
    input  logic                    rw_i,
    input  logic                    valid_i,

    output logic [BUS_WIDTH-1:0]    addr_o,
    output logic [BUS_WIDTH-1:0]    wdata_o,
    output logic [BUS_WIDTH-1:0]    rdata_o,
    output logic                    rw_o,
    output logic                    valid_o,

    output logic                    trig_o,
    output logic [SAMPLE_WIDTH-1:0] sample_o
);

    trig_op_e             op0, op1, op2, op3;
    logic                 arg0, arg1, arg2;
    logic [3:0]           arg3;
    logic [3:0]           probe_trig;

    logic [BUS_WIDTH-1:0] offset;
    logic                 hit;
    logic [BUS_WIDTH-1:0] reg_value;

    assign offset = addr_i - TRIG_BASE;
    assign hit    = valid_i && (offset < TRIG_REGS);

    // op/arg pairs, one per probe
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op0  <= DISABLE;
            op1  <= DISABLE;
            op2  <= DISABLE;
            op3  <= DISABLE;
            arg0 <= 1'b0;
            arg1 <= 1'b0;
            arg2 <= 1'b0;
            arg3 <= 4'd0;
        end else if (hit && rw_i) begin
            case (offset[2:0])
                3'd0: op0  <= trig_op_e'(wdata_i[3:0]);
                3'd1: arg0 <= wdata_i[0];
                3'd2: op1  <= trig_op_e'(wdata_i[3:0]);
                3'd3: arg1 <= wdata_i[0];
                3'd4: op2  <= trig_op_e'(wdata_i[3:0]);
                3'd5: arg2 <= wdata_i[0];
                3'd6: op3  <= trig_op_e'(wdata_i[3:0]);
                default: arg3 <= wdata_i[3:0];
            endcase
        end
    end

    always_comb begin
        case (offset[2:0])
            3'd0: reg_value = BUS_WIDTH'(op0);
            3'd1: reg_value = BUS_WIDTH'(arg0);
            3'd2: reg_value = BUS_WIDTH'(op1);
            3'd3: reg_value = BUS_WIDTH'(arg1);
            3'd4: reg_value = BUS_WIDTH'(op2);
            3'd5: reg_value = BUS_WIDTH'(arg2);
            3'd6: reg_value = BUS_WIDTH'(op3);
            default: reg_value = BUS_WIDTH'(arg3);
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_o  <= addr_i;
        wdata_o <= wdata_i;
        rw_o    <= rw_i;
        if (hit && !rw_i) begin
            rdata_o <= reg_value;
        end else begin
            rdata_o <= rdata_i;
        end
    end

    probe_trigger #(.INPUT_WIDTH(1)) u_trig0 (
        .clk(clk), .arst_n_i(arst_n_i), .probe_i(probe0_i),
        .op_i(op0), .arg_i(arg0), .trig_o(probe_trig[0])
    );

    probe_trigger #(.INPUT_WIDTH(1)) u_trig1 (
        .clk(clk), .arst_n_i(arst_n_i), .probe_i(probe1_i),
        .op_i(op1), .arg_i(arg1), .trig_o(probe_trig[1])
    );

    probe_trigger #(.INPUT_WIDTH(1)) u_trig2 (
        .clk(clk), .arst_n_i(arst_n_i), .probe_i(probe2_i),
        .op_i(op2), .arg_i(arg2), .trig_o(probe_trig[2])
    );

    probe_trigger #(.INPUT_WIDTH(4)) u_trig3 (
        .clk(clk), .arst_n_i(arst_n_i), .probe_i(probe3_i),
        .op_i(op3), .arg_i(arg3), .trig_o(probe_trig[3])
    );

    // trig and sample leave together, same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trig_o <= 1'b0;
        end else begin
            trig_o <= |probe_trig;
        end
    end

    always_ff @(posedge clk) begin
        sample_o <= {probe3_i, probe2_i, probe1_i, probe0_i};
    end

endmodule

// File: source/capture_control.sv
`timescale 1ns/100ps

module capture_control import la_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  logic [BUS_WIDTH-1:0]         addr_i,
    input  logic [BUS_WIDTH-1:0]         wdata_i,
    input  logic [BUS_WIDTH-1:0]         rdata_i,
    input  logic                         rw_i,
    input  logic                         valid_i,

    output logic [BUS_WIDTH-1:0]         addr_o,
    output logic [BUS_WIDTH-1:0]         wdata_o,
    output logic [BUS_WIDTH-1:0]         rdata_o,
    output logic                         rw_o,
    output logic                         valid_o,

    input  logic                         trig_i,
    input  logic [SAMPLE_WIDTH-1:0]      sample_i,

    output logic                         wr_en_o,
    output logic [SAMPLE_ADDR_WIDTH-1:0] wr_addr_o,
    output logic [SAMPLE_WIDTH-1:0]      wr_data_o
);

    cap_state_e                    state;
    logic [SAMPLE_COUNT_WIDTH-1:0] count;

    logic [BUS_WIDTH-1:0]          offset;
    logic                          hit;
    logic                          arm;
    logic [BUS_WIDTH-1:0]          reg_value;

    assign offset = addr_i - CAP_BASE;
    assign hit    = valid_i && (offset < CAP_REGS);
    assign arm    = hit && rw_i && (offset == CAP_CTRL) && wdata_i[0];

    // trigger cycle writes entry 0, then one entry per cycle
    assign wr_en_o   = ((state == ARMED) && trig_i) || (state == CAPTURING);
    assign wr_addr_o = count[SAMPLE_ADDR_WIDTH-1:0];
    assign wr_data_o = sample_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (arm) begin
                        state <= ARMED;
                        count <= '0;
                    end
                end
                ARMED: begin
                    if (trig_i) begin
                        state <= CAPTURING;
                        count <= count + 1'b1;
                    end
                end
                CAPTURING: begin
                    count <= count + 1'b1;
                    // last entry goes in this cycle
                    if (count == SAMPLE_COUNT_WIDTH'(SAMPLE_DEPTH - 1)) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // control reads back as 0
    always_comb begin
        case (offset)
            BUS_WIDTH'(CAP_STATUS): reg_value = BUS_WIDTH'(state);
            BUS_WIDTH'(CAP_COUNT):  reg_value = BUS_WIDTH'(count);
            default:                reg_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_o  <= addr_i;
        wdata_o <= wdata_i;
        rw_o    <= rw_i;
        if (hit && !rw_i) begin
            rdata_o <= reg_value;
        end else begin
            rdata_o <= rdata_i;
        end
    end

endmodule

// File: source/sample_mem.sv
`timescale 1ns/100ps

module sample_mem import la_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  logic [BUS_WIDTH-1:0]         addr_i,
    input  logic [BUS_WIDTH-1:0]         wdata_i,
    input  logic [BUS_WIDTH-1:0]         rdata_i,
    input  logic                         rw_i,
    input  logic                         valid_i,

    output logic [BUS_WIDTH-1:0]         addr_o,
    output logic [BUS_WIDTH-1:0]         wdata_o,
    output logic [BUS_WIDTH-1:0]         rdata_o,
    output logic                         rw_o,
    output logic                         valid_o,

    input  logic                         wr_en_i,
    input  logic [SAMPLE_ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [SAMPLE_WIDTH-1:0]      wr_data_i
);

    logic [SAMPLE_WIDTH-1:0] mem [SAMPLE_DEPTH];

    logic [BUS_WIDTH-1:0]    offset;
    logic                    hit;
    logic [BUS_WIDTH-1:0]    entry;

    assign offset = addr_i - MEM_BASE;
    assign hit    = valid_i && (offset < SAMPLE_DEPTH);

    // capture side port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // bus side sees the buffer read only
    assign entry = BUS_WIDTH'(mem[offset[SAMPLE_ADDR_WIDTH-1:0]]);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_o  <= addr_i;
        wdata_o <= wdata_i;
        rw_o    <= rw_i;
        if (hit && !rw_i) begin
            rdata_o <= entry;
        end else begin
            rdata_o <= rdata_i;
        end
    end

endmodule

// File: source/logic_analyzer.sv
`timescale 1ns/100ps

module logic_analyzer import la_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n_i,

    input  logic                 probe0_i,
    input  logic                 probe1_i,
    input  logic                 probe2_i,
    input  logic [3:0]           probe3_i,

    input  logic [BUS_WIDTH-1:0] addr_i,
    input  logic [BUS_WIDTH-1:0] wdata_i,
    input  logic                 rw_i,
    input  logic                 valid_i,

    output logic [BUS_WIDTH-1:0] addr_o,
    output logic [BUS_WIDTH-1:0] wdata_o,
    output logic [BUS_WIDTH-1:0] rdata_o,
    output logic                 rw_o,
    output logic                 valid_o
);

    // trigger_block to capture_control
    logic [BUS_WIDTH-1:0]         tc_addr, tc_wdata, tc_rdata;
    logic                         tc_rw, tc_valid;
    // capture_control to sample_mem
    logic [BUS_WIDTH-1:0]         cm_addr, cm_wdata, cm_rdata;
    logic                         cm_rw, cm_valid;

    logic                         trig;
    logic [SAMPLE_WIDTH-1:0]      sample;
    logic                         wr_en;
    logic [SAMPLE_ADDR_WIDTH-1:0] wr_addr;
    logic [SAMPLE_WIDTH-1:0]      wr_data;

    // head of the chain starts with empty read data
    trigger_block u_trigger (
        .clk(clk), .arst_n_i(arst_n_i),
        .probe0_i(probe0_i), .probe1_i(probe1_i),
        .probe2_i(probe2_i), .probe3_i(probe3_i),
        .addr_i(addr_i), .wdata_i(wdata_i), .rdata_i('0),
        .rw_i(rw_i), .valid_i(valid_i),
        .addr_o(tc_addr), .wdata_o(tc_wdata), .rdata_o(tc_rdata),
        .rw_o(tc_rw), .valid_o(tc_valid),
        .trig_o(trig), .sample_o(sample)
    );

    capture_control u_capture (
        .clk(clk), .arst_n_i(arst_n_i),
        .addr_i(tc_addr), .wdata_i(tc_wdata), .rdata_i(tc_rdata),
        .rw_i(tc_rw), .valid_i(tc_valid),
        .addr_o(cm_addr), .wdata_o(cm_wdata), .rdata_o(cm_rdata),
        .rw_o(cm_rw), .valid_o(cm_valid),
        .trig_i(trig), .sample_i(sample),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data)
    );

    sample_mem u_mem (
        .clk(clk), .arst_n_i(arst_n_i),
        .addr_i(cm_addr), .wdata_i(cm_wdata), .rdata_i(cm_rdata),
        .rw_i(cm_rw), .valid_i(cm_valid),
        .addr_o(addr_o), .wdata_o(wdata_o), .rdata_o(rdata_o),
        .rw_o(rw_o), .valid_o(valid_o),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data)
    );

endmodule

// File: bench/la_bus_tasks.svh
`ifndef LA_BUS_TASKS_SVH
`define LA_BUS_TASKS_SVH

int checks = 0;
int errors = 0;

// expected trigger configuration kept in step with bus writes
logic [3:0] model_op  [4] = '{4'h0, 4'h0, 4'h0, 4'h0};
logic [3:0] model_arg [4] = '{4'h0, 4'h0, 4'h0, 4'h0};

task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
        errors++;
    end
endtask

// one chain transfer that returns in the cycle valid_o comes out
task automatic bus_xfer(input logic rw, input logic [15:0] addr, input logic [15:0] data,
                        output logic [15:0] rdata);
    int latency;
    @(negedge clk);
    addr_i  = addr;
    wdata_i = data;
    rw_i    = rw;
    valid_i = 1'b1;
    @(negedge clk);
    valid_i = 1'b0;
    latency = 1;
    while (!valid_o && latency < 8) begin
        @(negedge clk);
        latency++;
    end
    rdata = '0;
    if (!valid_o) begin
        $display("transfer to address %h never came out of the bus chain", addr);
        errors++;
    end else begin
        check_value("valid_o latency", 16'(latency), 16'd3);
        check_value("addr_o", addr_o, addr);
        check_value("wdata_o", wdata_o, data);
        check_value("rw_o", 16'(rw_o), 16'(rw));
        rdata = rdata_o;
    end
endtask

task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
    logic [15:0] unused;
    bus_xfer(1'b1, addr, data, unused);
endtask

task automatic read_expect(input string name, input logic [15:0] addr, input logic [15:0] exp);
    logic [15:0] rdata;
    bus_xfer(1'b0, addr, 16'h0000, rdata);
    check_value(name, rdata, exp);
endtask

// arg first so the new op never sees a stale argument
task automatic set_trigger(input int idx, input logic [3:0] op, input logic [3:0] arg);
    write_reg(16'(TRIG_BASE + 2 * idx + 1), 16'(arg));
    write_reg(16'(TRIG_BASE + 2 * idx), 16'(op));
    model_op[idx]  = op;
    model_arg[idx] = (idx == 3) ? arg : {3'b000, arg[0]};
endtask

function automatic logic trig_fires(input logic [3:0] op, input logic [3:0] cur,
                                    input logic [3:0] prev, input logic [3:0] arg);
    case (op)
        RISING:   return cur[0] && !prev[0];
        FALLING:  return prev[0] && !cur[0];
        CHANGING: return cur != prev;
        GT:       return cur > arg;
        LT:       return cur < arg;
        GEQ:      return cur >= arg;
        LEQ:      return cur <= arg;
        EQ:       return cur == arg;
        NEQ:      return cur != arg;
        default:  return 1'b0;
    endcase
endfunction

function automatic logic any_fires(input logic [6:0] cur, input logic [6:0] prev);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 3; i++) begin
        hit |= trig_fires(model_op[i], {3'b000, cur[i]}, {3'b000, prev[i]}, model_arg[i]);
    end
    hit |= trig_fires(model_op[3], cur[6:3], prev[6:3], model_arg[3]);
    return hit;
endfunction

`endif

// File: bench/tb_logic_analyzer.sv
`timescale 1ns/100ps

module tb_logic_analyzer import la_pkg::*; ();

    // sequences take roughly 800 cycles
    localparam int MAX_CYCLES = 3000;
    localparam logic [3:0] EQ_VALUE = 4'hA;

    logic        clk;
    logic        arst_n_i;
    logic        probe0_i, probe1_i, probe2_i;
    logic [3:0]  probe3_i;
    logic [15:0] addr_i, wdata_i;
    logic        rw_i, valid_i;
    logic [15:0] addr_o, wdata_o, rdata_o;
    logic        rw_o, valid_o;

    logic [6:0]  cur_vec;
    logic [6:0]  history [$];
    logic [15:0] rdata;
    integer      seed = 32'h84309efb;
    int          cycle_count;
    int          trig_idx;

    `include "la_bus_tasks.svh"

    logic_analyzer uut (
        .clk(clk), .arst_n_i(arst_n_i),
        .probe0_i(probe0_i), .probe1_i(probe1_i), .probe2_i(probe2_i), .probe3_i(probe3_i),
        .addr_i(addr_i), .wdata_i(wdata_i), .rw_i(rw_i), .valid_i(valid_i),
        .addr_o(addr_o), .wdata_o(wdata_o), .rdata_o(rdata_o), .rw_o(rw_o), .valid_o(valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run still going after %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic drive_vector(input logic [6:0] vec);
        @(negedge clk);
        {probe3_i, probe2_i, probe1_i, probe0_i} = vec;
        cur_vec = vec;
        history.push_back(vec);
    endtask

    // random vector that the configured triggers ignore
    function automatic logic [6:0] quiet_vector();
        logic [6:0] vec;
        vec = 7'($random(seed));
        for (int n = 0; n < 50 && any_fires(vec, cur_vec); n++) begin
            vec = 7'($random(seed));
        end
        return vec;
    endfunction

    task automatic wait_done();
        logic [15:0] status;
        int polls;
        status = '0;
        polls = 0;
        while (status != 16'(DONE) && polls < 40) begin
            bus_xfer(1'b0, CAP_BASE + 16'(CAP_STATUS), 16'h0000, status);
            polls++;
        end
        if (status != 16'(DONE)) begin
            $display("capture status never reached DONE");
            errors++;
        end
    endtask

    task automatic check_capture(input int first);
        for (int i = 0; i < SAMPLE_DEPTH; i++) begin
            read_expect($sformatf("entry %0d", i), MEM_BASE + 16'(i), 16'(history[first + i]));
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        addr_i   = '0;
        wdata_i  = '0;
        rw_i     = 1'b0;
        valid_i  = 1'b0;
        {probe3_i, probe2_i, probe1_i, probe0_i} = 7'h00;
        cur_vec  = 7'h00;
        repeat (8) @(negedge clk);
        arst_n_i = 1'b1;
        check_value("valid_o", 16'(valid_o), 16'h0000);

        for (int i = 0; i < 8; i++) begin
            read_expect($sformatf("trigger reg %0d", i), TRIG_BASE + 16'(i), 16'h0000);
        end
        read_expect("status", CAP_BASE + 16'(CAP_STATUS), 16'(IDLE));
        read_expect("count", CAP_BASE + 16'(CAP_COUNT), 16'h0000);

        // op fields and the probe 3 arg keep 4 bits and other args 1 bit
        for (int i = 0; i < 8; i++) begin
            write_reg(TRIG_BASE + 16'(i), 16'h3C70 | 16'(i));
            read_expect($sformatf("trigger reg %0d", i), TRIG_BASE + 16'(i),
                        (i % 2 == 0 || i == 7) ? 16'(i) : 16'(i & 1));
        end
        for (int i = 0; i < 8; i++) begin
            write_reg(TRIG_BASE + 16'(i), 16'h0000);
        end
        read_expect("unmapped", 16'd40, 16'h0000);

        // EQ on probe 3
        set_trigger(3, EQ, EQ_VALUE);
        write_reg(CAP_BASE + 16'(CAP_CTRL), 16'h0001);
        read_expect("status", CAP_BASE + 16'(CAP_STATUS), 16'(ARMED));
        repeat (12) drive_vector(quiet_vector());
        history.delete();
        drive_vector({EQ_VALUE, 3'($random(seed))});
        repeat (20) drive_vector(7'($random(seed)));
        wait_done();
        read_expect("count", CAP_BASE + 16'(CAP_COUNT), 16'(SAMPLE_DEPTH));
        bus_xfer(1'b0, MEM_BASE, 16'h0000, rdata);
        check_value("entry 0 probe3", 16'(rdata[6:3]), 16'(EQ_VALUE));
        check_capture(0);

        // rising edge on probe 0
        drive_vector(7'($random(seed)) | 7'h01);
        set_trigger(3, DISABLE, 4'h0);
        set_trigger(0, RISING, 4'h0);
        write_reg(CAP_BASE + 16'(CAP_CTRL), 16'h0001);
        history.delete();
        repeat (5) drive_vector(quiet_vector());
        drive_vector(7'($random(seed)) & 7'h7E);
        trig_idx = history.size();
        drive_vector(7'($random(seed)) | 7'h01);
        repeat (20) drive_vector(7'($random(seed)));
        wait_done();
        bus_xfer(1'b0, MEM_BASE, 16'h0000, rdata);
        check_value("entry 0 probe0", 16'(rdata[0]), 16'h0001);
        check_capture(trig_idx);

        // capture must stay armed with nothing enabled
        set_trigger(0, DISABLE, 4'h0);
        write_reg(CAP_BASE + 16'(CAP_CTRL), 16'h0001);
        repeat (100) drive_vector(7'($random(seed)));
        read_expect("status", CAP_BASE + 16'(CAP_STATUS), 16'(ARMED));

        // reset in the middle of a capture
        set_trigger(1, CHANGING, 4'h0);
        set_trigger(3, DISABLE, 4'h5);
        drive_vector(cur_vec ^ 7'h02);
        repeat (3) drive_vector(cur_vec);
        read_expect("status", CAP_BASE + 16'(CAP_STATUS), 16'(CAPTURING));
        @(negedge clk);
        arst_n_i = 1'b0;
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;
        read_expect("status", CAP_BASE + 16'(CAP_STATUS), 16'(IDLE));
        read_expect("count", CAP_BASE + 16'(CAP_COUNT), 16'h0000);
        for (int i = 0; i < 8; i++) begin
            read_expect($sformatf("trigger reg %0d", i), TRIG_BASE + 16'(i), 16'h0000);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
source/la_pkg.sv
source/probe_trigger.sv
source/trigger_block.sv
source/capture_control.sv
source/sample_mem.sv
source/logic_analyzer.sv
bench/tb_logic_analyzer.sv
